/* warp_buffer_config.svh */
`ifndef WARP_BUFFER_CONFIG_SVH
`define WARP_BUFFER_CONFIG_SVH

////////////////////////////////////////////////////////////
// image geometry
////////////////////////////////////////////////////////////

`define WB_WIDTH 16
`define WB_HEIGHT 12

// samples per beat, a bank word is a pair so this stays at 4
`define WB_NPPC 4
`define WB_BPP 8

////////////////////////////////////////////////////////////
// vertical reach and generated row spacing
////////////////////////////////////////////////////////////

// up + down must be even so the ring keeps row parity
`define WB_MAX_SHIFT_UP 2
`define WB_MAX_SHIFT_DOWN 2
`define WB_LINE_BREAK 4

`endif

/* warp_buffer_pkg.sv */
`default_nettype none
`include "warp_buffer_config.svh"

package warp_buffer_pkg;

  // rows kept in the ring: both reaches, the current row and the write row
  localparam int BUFFER_LINES = `WB_MAX_SHIFT_UP + `WB_MAX_SHIFT_DOWN + 2;

  // words per bank, half the rows and one word per beat
  localparam int BANK_DEPTH = (BUFFER_LINES / 2) * (`WB_WIDTH / `WB_NPPC);

  ////////////////////////////////////////////////////////////
  // payload types
  ////////////////////////////////////////////////////////////

  typedef logic [`WB_BPP-1:0] pixel_t;

  // [0] is the lower column of the pair, [1] the column two to the right
  typedef pixel_t [1:0] pixel_pair_t;

  typedef pixel_t [`WB_NPPC-1:0] beat_t;

  ////////////////////////////////////////////////////////////
  // positions and addresses
  ////////////////////////////////////////////////////////////

  typedef logic [$clog2(`WB_WIDTH)-1:0] pos_x_t;
  typedef logic [$clog2(`WB_HEIGHT)-1:0] pos_y_t;

  typedef pos_x_t [`WB_NPPC-1:0] pos_vec_x_t;
  typedef pos_y_t [`WB_NPPC-1:0] pos_vec_y_t;

  typedef logic [$clog2(BANK_DEPTH)-1:0] bank_addr_t;

  typedef enum logic [1:0] {SYNCH, SKIP_LINES, NORMAL, GEN_LINES} seq_state_t;

endpackage

`default_nettype wire

/* warp_buffer_if.sv */
`timescale 1ns/10ps
`default_nettype none
`include "warp_buffer_config.svh"

// shared bank write port
interface line_write_if import warp_buffer_pkg::*; ();
  // row parity of the word in flight
  logic        bank_sel;
  logic        strobe;
  bank_addr_t  addr_even;
  bank_addr_t  addr_odd;
  // samples 0/2 and 1/3 of the beat
  pixel_pair_t even_pair;
  pixel_pair_t odd_pair;

  modport writer (output bank_sel, strobe, addr_even, addr_odd, even_pair, odd_pair);
  modport store  (input  bank_sel, strobe, addr_even, addr_odd, even_pair, odd_pair);
endinterface

// registered bank words per sample, by row parity then column parity
interface bank_read_if import warp_buffer_pkg::*; ();
  pixel_pair_t [`WB_NPPC-1:0] word_00;
  pixel_pair_t [`WB_NPPC-1:0] word_01;
  pixel_pair_t [`WB_NPPC-1:0] word_10;
  pixel_pair_t [`WB_NPPC-1:0] word_11;

  modport source (output word_00, word_01, word_10, word_11);
  modport sink   (input  word_00, word_01, word_10, word_11);
endinterface

`default_nettype wire

/* line_writer.sv */
`timescale 1ns/10ps
`default_nettype none

module line_writer import warp_buffer_pkg::*; (
  input  logic  aclk,
  input  logic  aresetn,
  input  beat_t s_axis_tdata,
  input  logic  s_axis_tvalid,
  input  logic  s_axis_tlast,
  input  logic  s_axis_tuser,
  line_write_if.writer wr
);

  // parity of the row the next beat belongs to
  logic row_parity;

  function automatic bank_addr_t next_addr(input bank_addr_t addr);
    return (addr == bank_addr_t'(BANK_DEPTH - 1)) ? '0 : addr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // write control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr.strobe    <= 1'b0;
      wr.bank_sel  <= 1'b0;
      wr.addr_even <= '0;
      wr.addr_odd  <= '0;
      row_parity   <= 1'b0;
    end else begin
      wr.strobe <= s_axis_tvalid;

      // bump the bank that takes the word this cycle
      if (wr.strobe && !wr.bank_sel) begin
        wr.addr_even <= next_addr(wr.addr_even);
      end
      if (wr.strobe && wr.bank_sel) begin
        wr.addr_odd <= next_addr(wr.addr_odd);
      end

      if (s_axis_tvalid) begin
        wr.bank_sel <= s_axis_tuser ? 1'b0 : row_parity;
        row_parity  <= (s_axis_tuser ? 1'b0 : row_parity) ^ s_axis_tlast;
        // frame start puts row 0 at the ring origin
        if (s_axis_tuser) begin
          wr.addr_even <= '0;
          wr.addr_odd  <= '0;
        end
      end
    end
  end

  // pair packing by column parity
  always_ff @(posedge aclk) begin
    if (s_axis_tvalid) begin
      wr.even_pair <= {s_axis_tdata[2], s_axis_tdata[0]};
      wr.odd_pair  <= {s_axis_tdata[3], s_axis_tdata[1]};
    end
  end

endmodule

`default_nettype wire

/* frame_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "warp_buffer_config.svh"

module frame_sequencer import warp_buffer_pkg::*; (
  input  logic aclk,
  input  logic aresetn,
  input  logic s_axis_tvalid,
  input  logic s_axis_tlast,
  input  logic s_axis_tuser,
  output logic out_valid,
  output logic out_last,
  output logic out_user
);

  localparam int BEATS     = `WB_WIDTH / `WB_NPPC;
  localparam int SKIP_ROWS = `WB_MAX_SHIFT_DOWN + 1;
  localparam int GEN_LEN   = `WB_LINE_BREAK + BEATS;
  localparam int COL_W     = $clog2(BEATS + 1);
  localparam int GEN_W     = $clog2(GEN_LEN + 1);
  localparam int GROW_W    = $clog2(SKIP_ROWS + 1);

  localparam pos_y_t LAST_SKIP_ROW = pos_y_t'(SKIP_ROWS - 1);
  localparam pos_y_t FIRST_OUT_ROW = pos_y_t'(SKIP_ROWS);
  localparam pos_y_t LAST_ROW      = pos_y_t'(`WB_HEIGHT - 1);

  seq_state_t        state;
  logic              tvalid_d;
  logic              tlast_d;
  logic              tuser_d;
  logic [COL_W-1:0]  col;
  logic [COL_W-1:0]  cur_col;
  pos_y_t            row;
  pos_y_t            cur_row;
  logic              frame_seen;
  logic              resync;
  logic [GEN_W-1:0]  gen_cnt;
  logic [GROW_W-1:0] gen_row;
  logic              gen_end;

  // input flags, aligned with the bank write
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      tvalid_d <= 1'b0;
      tlast_d  <= 1'b0;
      tuser_d  <= 1'b0;
    end else begin
      tvalid_d <= s_axis_tvalid;
      tlast_d  <= s_axis_tlast;
      tuser_d  <= s_axis_tuser;
    end
  end

  ////////////////////////////////////////////////////////////
  // input position
  ////////////////////////////////////////////////////////////

  assign cur_col = tuser_d ? '0 : col;
  assign cur_row = tuser_d ? '0 : row;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      col        <= '0;
      row        <= '0;
      frame_seen <= 1'b0;
    end else if (tvalid_d) begin
      col <= tlast_d ? '0 : cur_col + 1'b1;
      row <= tlast_d ? cur_row + 1'b1 : cur_row;
      // a complete row means the next tuser opens a whole frame
      if (tlast_d && cur_col == COL_W'(BEATS - 1)) begin
        frame_seen <= 1'b1;
      end
    end
  end

  assign resync  = tvalid_d && tuser_d && frame_seen;
  assign gen_end = (gen_cnt == GEN_W'(GEN_LEN - 1));

  ////////////////////////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state   <= SYNCH;
      gen_cnt <= '0;
      gen_row <= '0;
    end else begin
      case (state)
        SYNCH: begin
          if (resync) begin
            state <= SKIP_LINES;
          end
        end
        SKIP_LINES: begin
          if (tvalid_d && tlast_d && cur_row == LAST_SKIP_ROW) begin
            state <= NORMAL;
          end
        end
        NORMAL: begin
          if (tvalid_d && tlast_d && cur_row == LAST_ROW) begin
            state   <= GEN_LINES;
            gen_cnt <= '0;
            gen_row <= '0;
          end
        end
        GEN_LINES: begin
          gen_cnt <= gen_end ? '0 : gen_cnt + 1'b1;
          if (gen_end) begin
            gen_row <= gen_row + 1'b1;
            if (gen_row == GROW_W'(SKIP_ROWS - 1)) begin
              state <= SKIP_LINES;
            end
          end
        end
        default: state <= SYNCH;
      endcase
    end
  end

  // output flags, the resync beat is already row 0 of a skipped band
  always_comb begin
    out_valid = 1'b0;
    out_last  = 1'b0;
    out_user  = 1'b0;
    case (state)
      SYNCH: begin
        out_valid = tvalid_d && !resync;
        out_last  = tvalid_d && tlast_d && !resync;
        out_user  = tvalid_d && tuser_d && !resync;
      end
      NORMAL: begin
        out_valid = tvalid_d;
        out_last  = tvalid_d && tlast_d;
        out_user  = tvalid_d && cur_row == FIRST_OUT_ROW && cur_col == '0;
      end
      GEN_LINES: begin
        // idle gap first, then one row of beats
        out_valid = (gen_cnt >= GEN_W'(`WB_LINE_BREAK));
        out_last  = gen_end;
      end
      default: begin
        out_valid = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* quad_line_store.sv */
`timescale 1ns/10ps
`default_nettype none
`include "warp_buffer_config.svh"

module quad_line_store import warp_buffer_pkg::*; (
  input  logic        aclk,
  line_write_if.store wr,
  input  pos_vec_x_t  pos_x,
  input  pos_vec_y_t  pos_y,
  bank_read_if.source rd
);

  localparam int BEATS = `WB_WIDTH / `WB_NPPC;

  bank_addr_t                 wr_addr;
  pixel_pair_t [`WB_NPPC-1:0] dout [2][2];

  // row slot pairs share a word line, one word per beat
  function automatic bank_addr_t word_addr(input pos_y_t slot, input pos_x_t col);
    return bank_addr_t'((slot >> 1) * BEATS + col / `WB_NPPC);
  endfunction

  assign wr_addr = wr.bank_sel ? wr.addr_odd : wr.addr_even;

  for (genvar i = 0; i < `WB_NPPC; i++) begin : g_sample
    pos_y_t slot_y0;
    pos_y_t slot_y1;
    pos_x_t col_x1;

    // ring slots of rows y and y+1
    assign slot_y0 = pos_y_t'(pos_y[i] % BUFFER_LINES);
    assign slot_y1 = (slot_y0 == pos_y_t'(BUFFER_LINES - 1)) ? '0 : slot_y0 + 1'b1;
    // x+1 wraps at the row end
    assign col_x1  = (pos_x[i] == pos_x_t'(`WB_WIDTH - 1)) ? '0 : pos_x[i] + 1'b1;

    for (genvar r = 0; r < 2; r++) begin : g_row
      for (genvar c = 0; c < 2; c++) begin : g_col
        pixel_pair_t mem [BANK_DEPTH];
        pixel_pair_t rd_word;
        bank_addr_t  rd_addr;

        // bank r/c serves whichever row and column of the quad has that parity
        assign rd_addr = word_addr((pos_y[i][0] == 1'(r)) ? slot_y0 : slot_y1,
                                   (pos_x[i][0] == 1'(c)) ? pos_x[i] : col_x1);

        always_ff @(posedge aclk) begin
          if (wr.strobe && wr.bank_sel == 1'(r)) begin
            mem[wr_addr] <= (c == 0) ? wr.even_pair : wr.odd_pair;
          end
          rd_word <= mem[rd_addr];
        end

        assign dout[r][c][i] = rd_word;
      end
    end
  end

  assign rd.word_00 = dout[0][0];
  assign rd.word_01 = dout[0][1];
  assign rd.word_10 = dout[1][0];
  assign rd.word_11 = dout[1][1];

endmodule

`default_nettype wire

/* neighbour_select.sv */
`timescale 1ns/10ps
`default_nettype none
`include "warp_buffer_config.svh"

module neighbour_select import warp_buffer_pkg::*; (
  input  logic       aclk,
  input  pos_vec_x_t pos_x,
  input  pos_vec_y_t pos_y,
  bank_read_if.sink  rd,
  output beat_t      tap_00,
  output beat_t      tap_01,
  output beat_t      tap_10,
  output beat_t      tap_11
);

  pos_vec_x_t pos_x_q;
  pos_vec_y_t pos_y_q;

  // positions ride along with the bank read
  always_ff @(posedge aclk) begin
    pos_x_q <= pos_x;
    pos_y_q <= pos_y;
  end

  for (genvar i = 0; i < `WB_NPPC; i++) begin : g_sample
    pixel_pair_t word [2][2];
    logic        row_p;
    logic        col_p;
    pos_x_t      col_x1;

    assign word[0][0] = rd.word_00[i];
    assign word[0][1] = rd.word_01[i];
    assign word[1][0] = rd.word_10[i];
    assign word[1][1] = rd.word_11[i];

    assign row_p  = pos_y_q[i][0];
    assign col_p  = pos_x_q[i][0];
    assign col_x1 = (pos_x_q[i] == pos_x_t'(`WB_WIDTH - 1)) ? '0 : pos_x_q[i] + 1'b1;

    // bit 1 of a column picks the pixel inside its pair
    assign tap_00[i] = word[row_p][col_p][pos_x_q[i][1]];
    assign tap_01[i] = word[row_p][~col_p][col_x1[1]];
    assign tap_10[i] = word[~row_p][col_p][pos_x_q[i][1]];
    assign tap_11[i] = word[~row_p][~col_p][col_x1[1]];
  end

endmodule

`default_nettype wire

/* warp_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module warp_buffer import warp_buffer_pkg::*; (
  input  logic       aclk,
  input  logic       aresetn,

  input  beat_t      s_axis_tdata,
  input  logic       s_axis_tvalid,
  input  logic       s_axis_tlast,
  input  logic       s_axis_tuser,

  output logic       new_pos_tready,
  output logic       new_pos_tuser,
  input  logic       new_pos_tvalid,
  input  pos_vec_x_t new_pos_x,
  input  pos_vec_y_t new_pos_y,

  output beat_t      m_axis_00_tdata,
  output beat_t      m_axis_01_tdata,
  output beat_t      m_axis_10_tdata,
  output beat_t      m_axis_11_tdata,
  output logic       m_axis_tvalid,
  output logic       m_axis_tlast,
  output logic       m_axis_tuser
);

  line_write_if wr_bus ();
  bank_read_if  rd_bus ();

  logic       out_valid;
  logic       out_last;
  logic       out_user;
  pos_vec_x_t req_x;
  pos_vec_y_t req_y;

  // no request, read the origin
  assign req_x = new_pos_tvalid ? new_pos_x : '0;
  assign req_y = new_pos_tvalid ? new_pos_y : '0;

  line_writer u_line_writer (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tuser  (s_axis_tuser),
    .wr            (wr_bus.writer)
  );

  frame_sequencer u_frame_sequencer (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tuser  (s_axis_tuser),
    .out_valid     (out_valid),
    .out_last      (out_last),
    .out_user      (out_user)
  );

  quad_line_store u_quad_line_store (
    .aclk  (aclk),
    .wr    (wr_bus.store),
    .pos_x (req_x),
    .pos_y (req_y),
    .rd    (rd_bus.source)
  );

  neighbour_select u_neighbour_select (
    .aclk   (aclk),
    .pos_x  (req_x),
    .pos_y  (req_y),
    .rd     (rd_bus.sink),
    .tap_00 (m_axis_00_tdata),
    .tap_01 (m_axis_01_tdata),
    .tap_10 (m_axis_10_tdata),
    .tap_11 (m_axis_11_tdata)
  );

  // requests are taken while the sequencer marks a beat
  assign new_pos_tready = out_valid;
  assign new_pos_tuser  = out_user;

  ////////////////////////////////////////////////////////////
  // output flags, aligned with the bank read latency
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_axis_tvalid <= 1'b0;
      m_axis_tlast  <= 1'b0;
      m_axis_tuser  <= 1'b0;
    end else begin
      m_axis_tvalid <= out_valid;
      m_axis_tlast  <= out_last;
      m_axis_tuser  <= out_user;
    end
  end

endmodule

`default_nettype wire

/* warp_buffer_props.sv */
`timescale 1ns/10ps
`default_nettype none

module warp_buffer_props import warp_buffer_pkg::*; (
  input logic       aclk,
  input logic       aresetn,
  input logic       new_pos_tready,
  input logic       m_axis_tvalid,
  input logic       m_axis_tlast,
  input logic       m_axis_tuser,
  input seq_state_t seq_state
);

  // output valid is the request ready one cycle later
  a_valid_follows_ready: assert property (@(posedge aclk) disable iff (!aresetn)
    $past(aresetn) |-> m_axis_tvalid == $past(new_pos_tready))
    else $error("m_axis_tvalid does not follow new_pos_tready");

  a_last_needs_valid: assert property (@(posedge aclk) disable iff (!aresetn)
    m_axis_tlast |-> m_axis_tvalid)
    else $error("m_axis_tlast set without m_axis_tvalid");

  // generated rows never open a frame
  a_no_user_in_gen: assert property (@(posedge aclk) disable iff (!aresetn)
    $past(seq_state) == GEN_LINES |-> !m_axis_tuser)
    else $error("m_axis_tuser set on a generated row");

endmodule

bind warp_buffer warp_buffer_props u_warp_buffer_props (
  .aclk           (aclk),
  .aresetn        (aresetn),
  .new_pos_tready (new_pos_tready),
  .m_axis_tvalid  (m_axis_tvalid),
  .m_axis_tlast   (m_axis_tlast),
  .m_axis_tuser   (m_axis_tuser),
  .seq_state      (u_frame_sequencer.state)
);

`default_nettype wire

/* warp_buffer_checker.sv */
`timescale 1ns/10ps
`default_nettype none
`include "warp_buffer_config.svh"

module warp_buffer_checker import warp_buffer_pkg::*; (
  input  logic       aclk,
  input  logic       aresetn,
  input  beat_t      s_axis_tdata,
  input  logic       s_axis_tvalid,
  input  logic       s_axis_tlast,
  input  logic       s_axis_tuser,
  input  logic       new_pos_tready,
  input  logic       new_pos_tuser,
  input  logic       new_pos_tvalid,
  input  pos_vec_x_t new_pos_x,
  input  pos_vec_y_t new_pos_y,
  input  beat_t      m_axis_00_tdata,
  input  beat_t      m_axis_01_tdata,
  input  beat_t      m_axis_10_tdata,
  input  beat_t      m_axis_11_tdata,
  input  logic       m_axis_tvalid,
  input  logic       m_axis_tlast,
  input  logic       m_axis_tuser,
  input  logic       test_end,
  input  int         test_idx,
  input  int         test_rows_exp,
  output int         rows_seen,
  output int         check_count,
  output int         error_count
);

  localparam int W     = `WB_WIDTH;
  localparam int H     = `WB_HEIGHT;
  localparam int BEATS = W / `WB_NPPC;

  // reference copy of the current frame
  pixel_t              ref_pix [H][W];
  logic                row_ok [H];
  beat_t               exp_tap [4];
  logic [`WB_NPPC-1:0] exp_on;
  // input beat that reaches the banks one cycle later
  logic                land_v;
  logic                land_l;
  logic                land_u;
  beat_t               land_data;
  int                  land_row;
  int                  land_col;
  int                  in_row;
  int                  in_col;
  int                  tuser_seen;
  logic [1:0]          hist_v;
  logic [1:0]          hist_en;
  int                  out_beat;
  int                  base_rows;
  int                  base_chk;
  int                  base_err;

  task automatic check_value(input string name, input int idx, input int got, input int exp);
    check_count++;
    if (got != exp) begin
      error_count++;
      $display("[ERROR] %0t %s[%0d]: got %h, expected %h", $time, name, idx, got, exp);
    end
  endtask

  always @(posedge aclk) begin
    if (!aresetn) begin
      exp_on     = '0;
      land_v     = 1'b0;
      in_row     = 0;
      in_col     = 0;
      tuser_seen = 0;
      hist_v     = '0;
      hist_en    = '0;
      out_beat   = 0;
      foreach (row_ok[r]) row_ok[r] = 1'b0;
    end else begin
      // taps for the request of the previous cycle
      for (int i = 0; i < `WB_NPPC; i++) begin
        if (exp_on[i]) begin
          check_value("m_axis_00_tdata", i, m_axis_00_tdata[i], exp_tap[0][i]);
          check_value("m_axis_01_tdata", i, m_axis_01_tdata[i], exp_tap[1][i]);
          check_value("m_axis_10_tdata", i, m_axis_10_tdata[i], exp_tap[2][i]);
          check_value("m_axis_11_tdata", i, m_axis_11_tdata[i], exp_tap[3][i]);
        end
      end
      exp_on = '0;

      // valid two cycles after each input beat that is not in a skipped band
      if (hist_en[1]) begin
        check_value("m_axis_tvalid", 0, m_axis_tvalid, hist_v[1]);
      end

      ////////////////////////////////////////////////////////////
      // output framing
      ////////////////////////////////////////////////////////////
      if (m_axis_tvalid) begin
        check_value("m_axis_tlast", 0, m_axis_tlast, out_beat == BEATS - 1);
        check_value("m_axis_tuser", 0, m_axis_tuser, (rows_seen % H == 0) && out_beat == 0);
        if (out_beat == BEATS - 1) begin
          out_beat = 0;
          rows_seen++;
        end else begin
          out_beat++;
        end
      end else if (m_axis_tlast || m_axis_tuser) begin
        error_count++;
        $display("%0t: tlast or tuser set on a cycle without tvalid", $time);
      end

      // request strobe marks the first beat of the next output frame
      check_value("new_pos_tuser", 0, new_pos_tuser,
                  new_pos_tready && (rows_seen % H == 0) && out_beat == 0);

      // only rows that are complete and not yet overwritten qualify
      if (new_pos_tready && new_pos_tvalid) begin
        for (int i = 0; i < `WB_NPPC; i++) begin
          int x;
          int y;
          x = new_pos_x[i];
          y = new_pos_y[i];
          if (x < W - 1 && y < H - 1 && row_ok[y] && row_ok[y + 1]) begin
            exp_on[i]     = 1'b1;
            exp_tap[0][i] = ref_pix[y][x];
            exp_tap[1][i] = ref_pix[y][x + 1];
            exp_tap[2][i] = ref_pix[y + 1][x];
            exp_tap[3][i] = ref_pix[y + 1][x + 1];
          end
        end
      end

      // bank write of the beat from the previous cycle
      if (land_v) begin
        if (land_u) begin
          foreach (row_ok[r]) row_ok[r] = 1'b0;
        end
        if (land_col == 0 && land_row >= BUFFER_LINES) begin
          row_ok[land_row - BUFFER_LINES] = 1'b0;
        end
        for (int k = 0; k < `WB_NPPC; k++) begin
          ref_pix[land_row][land_col * `WB_NPPC + k] = land_data[k];
        end
        if (land_l) begin
          row_ok[land_row] = 1'b1;
        end
      end

      land_v = s_axis_tvalid;
      if (s_axis_tvalid) begin
        if (s_axis_tuser) begin
          in_row = 0;
          in_col = 0;
          tuser_seen++;
        end
        land_l    = s_axis_tlast;
        land_u    = s_axis_tuser;
        land_data = s_axis_tdata;
        land_row  = in_row;
        land_col  = in_col;
        in_row    = s_axis_tlast ? in_row + 1 : in_row;
        in_col    = s_axis_tlast ? 0 : in_col + 1;
      end
      // first frame passes through, later frames drop their leading rows
      hist_v  = {hist_v[0], s_axis_tvalid &&
                 (tuser_seen < 2 || land_row >= `WB_MAX_SHIFT_DOWN + 1)};
      hist_en = {hist_en[0], tuser_seen < 2 || s_axis_tvalid};

      if (test_end) begin
        if (rows_seen - base_rows != test_rows_exp) begin
          error_count++;
          $display("test %0d produced %0d output rows where %0d were expected",
                   test_idx, rows_seen - base_rows, test_rows_exp);
        end
        $display("test %0d: %0d rows, %0d checks, %0d errors", test_idx,
                 rows_seen - base_rows, check_count - base_chk, error_count - base_err);
        base_rows = rows_seen;
        base_chk  = check_count;
        base_err  = error_count;
      end
    end
  end

  initial begin
    rows_seen   = 0;
    check_count = 0;
    error_count = 0;
    base_rows   = 0;
    base_chk    = 0;
    base_err    = 0;
  end

endmodule

`default_nettype wire

/* warp_buffer_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "warp_buffer_config.svh"

module warp_buffer_tb import warp_buffer_pkg::*; ();

  localparam int BEATS     = `WB_WIDTH / `WB_NPPC;
  localparam int FRAME_GAP = 3 * (`WB_LINE_BREAK + BEATS) + 8;
  localparam int MAX_TESTS = 16;
  localparam int TIMEOUT   = 4000;

  logic       aclk;
  logic       aresetn;
  beat_t      s_axis_tdata;
  logic       s_axis_tvalid;
  logic       s_axis_tlast;
  logic       s_axis_tuser;
  logic       new_pos_tready;
  logic       new_pos_tuser;
  logic       new_pos_tvalid;
  pos_vec_x_t new_pos_x;
  pos_vec_y_t new_pos_y;
  beat_t      m_axis_00_tdata;
  beat_t      m_axis_01_tdata;
  beat_t      m_axis_10_tdata;
  beat_t      m_axis_11_tdata;
  logic       m_axis_tvalid;
  logic       m_axis_tlast;
  logic       m_axis_tuser;

  logic        test_end;
  int          test_idx;
  int          test_rows_exp;
  int          rows_seen;
  int          check_count;
  int          error_count;
  logic [11:0] tests [MAX_TESTS];
  logic [15:0] lfsr;

  warp_buffer u_warp_buffer (.*);

  warp_buffer_checker u_warp_buffer_checker (.*);

  always #5 aclk = ~aclk;

  ////////////////////////////////////////////////////////////
  // pseudo random source
  ////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int k = 0; k < n; k++) begin
      v    = (v << 1) | lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // rows a few lines behind the input row, x fixed or random
  task automatic drive_positions(input int row, input int xsel, input int dysel);
    int x;
    int dy;
    int y;
    for (int i = 0; i < `WB_NPPC; i++) begin
      x = xsel;
      if (xsel == 15) begin
        take_bits(4, x);
        x = (x == 15) ? 14 : x;
      end
      dy = dysel;
      if (dysel == 0) begin
        take_bits(2, dy);
        dy = dy + 2;
      end
      y = row - dy;
      y = (y < 0) ? 0 : (y > `WB_HEIGHT - 2) ? `WB_HEIGHT - 2 : y;
      new_pos_x[i] = pos_x_t'(x);
      new_pos_y[i] = pos_y_t'(y);
    end
  endtask

  task automatic drive_beat(input logic v, input logic l, input logic u, input int row,
                            input int xsel, input int dysel);
    int p;
    @(negedge aclk);
    s_axis_tvalid = v;
    s_axis_tlast  = v & l;
    s_axis_tuser  = v & u;
    if (v) begin
      for (int k = 0; k < `WB_NPPC; k++) begin
        take_bits(`WB_BPP, p);
        s_axis_tdata[k] = pixel_t'(p);
      end
    end
    drive_positions(row, xsel, dysel);
  endtask

  task automatic drive_frame(input int xsel, input int dysel);
    for (int r = 0; r < `WB_HEIGHT; r++) begin
      for (int c = 0; c < BEATS; c++) begin
        drive_beat(1'b1, c == BEATS - 1, r == 0 && c == 0, r, xsel, dysel);
      end
    end
    // room for the generated rows before the next frame
    for (int g = 0; g < FRAME_GAP; g++) begin
      drive_beat(1'b0, 1'b0, 1'b0, `WB_HEIGHT, xsel, dysel);
    end
  endtask

  initial begin
    int target;
    int cnt;
    int frames;
    aclk           = 1'b0;
    aresetn        = 1'b0;
    s_axis_tdata   = '0;
    s_axis_tvalid  = 1'b0;
    s_axis_tlast   = 1'b0;
    s_axis_tuser   = 1'b0;
    new_pos_tvalid = 1'b0;
    new_pos_x      = '0;
    new_pos_y      = '0;
    test_end       = 1'b0;
    test_idx       = 0;
    test_rows_exp  = 0;
    lfsr           = 16'd4;
    target         = 0;
    foreach (tests[t]) tests[t] = '0;
    $readmemh("warp_buffer_tests.txt", tests);

    repeat (4) @(posedge aclk);
    @(negedge aclk);
    aresetn        = 1'b1;
    new_pos_tvalid = 1'b1;
    // idle stretch, flags must stay low
    repeat (6) @(negedge aclk);

    for (int t = 0; t < MAX_TESTS && tests[t][11:8] != 0; t++) begin
      frames        = tests[t][11:8];
      test_idx      = t;
      test_rows_exp = frames * `WB_HEIGHT;
      target        = target + test_rows_exp;
      for (int f = 0; f < frames; f++) begin
        drive_frame(tests[t][7:4], tests[t][3:0]);
      end
      cnt = 0;
      while (rows_seen < target && cnt < TIMEOUT) begin
        @(negedge aclk);
        cnt++;
      end
      if (rows_seen < target) begin
        $display("timeout in test %0d: %0d of %0d output rows seen", t, rows_seen, target);
        $display("Regression failed");
        $finish;
      end
      @(negedge aclk);
      test_end = 1'b1;
      @(negedge aclk);
      test_end = 1'b0;
    end

    repeat (4) @(negedge aclk);
    $display("total: %0d rows, %0d checks, %0d errors", rows_seen, check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* warp_buffer_tests.txt */
// one test per line: frames _ request column x (F random) _ row distance dy (0 random)
// all fields hex, frames are streamed with a gap for the generated rows
1_F_0
2_F_0
1_0_2
1_1_3
1_E_2
1_D_5
2_6_4
1_7_0
1_F_3
3_F_0

/* tb.f */
+incdir+.
warp_buffer_pkg.sv
warp_buffer_if.sv
line_writer.sv
frame_sequencer.sv
quad_line_store.sv
neighbour_select.sv
warp_buffer.sv
warp_buffer_props.sv
warp_buffer_checker.sv
warp_buffer_tb.sv

/* Bender.yml */
package:
  name: warp_buffer

export_include_dirs:
  - .

sources:
  - warp_buffer_pkg.sv
  - warp_buffer_if.sv
  - line_writer.sv
  - frame_sequencer.sv
  - quad_line_store.sv
  - neighbour_select.sv
  - warp_buffer.sv
  - target: test
    files:
      - warp_buffer_props.sv
      - warp_buffer_checker.sv
      - warp_buffer_tb.sv
